// File: logic/move_gen_pkg.sv
package move_gen_pkg;

	localparam int NUM_COLS = 8;
	localparam int NUM_ROWS = 8;
	localparam int PIECE_W = 4;
	localparam int NUM_OFFSETS = 8;
	localparam int COL_FIFO_DEPTH = 8;
	localparam int OUT_FIFO_DEPTH = 32;
	localparam int FLAG_CAPTURE = 0;

	// bit 3 colour (1 black), bits 2..0 kind
	typedef logic [PIECE_W-1:0] piece_t;

	typedef enum logic [2:0] {
		EMPTY  = 3'd0,
		PAWN   = 3'd1,
		KNIGHT = 3'd2,
		BISHOP = 3'd3,
		ROOK   = 3'd4,
		QUEEN  = 3'd5,
		KING   = 3'd6
	} piece_kind_e;

	// square (c, r) sits at bit 32*r + 4*c
	typedef logic [NUM_COLS*NUM_ROWS*PIECE_W-1:0] board_t;
	typedef logic [2:0] coord_t;
	// column on top, row below
	typedef logic [5:0] square_t;
	// invalid, promote, pawn move, pawn 2 sq, en passant, castle, capture
	typedef logic [6:0] flags_t;
	typedef logic [NUM_COLS*NUM_ROWS-1:0] sq_mask_t;
	typedef logic signed [3:0] delta_t;

	typedef struct packed {
		flags_t flags;
		square_t from_sq;
		square_t to_sq;
	} move_t;

	typedef struct packed {
		sq_mask_t friendly;
		sq_mask_t enemy;
		sq_mask_t knight;
		sq_mask_t king;
	} board_view_t;

	localparam delta_t KNIGHT_DC [NUM_OFFSETS] = '{1, 2, 2, 1, -1, -2, -2, -1};
	localparam delta_t KNIGHT_DR [NUM_OFFSETS] = '{2, 1, -1, -2, -2, -1, 1, 2};
	localparam delta_t KING_DC [NUM_OFFSETS] = '{0, 1, 1, 1, 0, -1, -1, -1};
	localparam delta_t KING_DR [NUM_OFFSETS] = '{1, 1, 0, -1, -1, -1, 0, 1};

	typedef enum logic {GEN_SCAN, GEN_DONE} gen_state_e;
	typedef enum logic [1:0] {WAIT = 2'b01, GETM = 2'b11, DONE = 2'b10} coll_state_e;

endpackage

// File: logic/board_decoder.sv
`timescale 1ns/100ps

module board_decoder (
	input move_gen_pkg::board_t bstate,
	input logic side_to_move,
	output move_gen_pkg::board_view_t view
);
	import move_gen_pkg::*;

	always_comb begin
		piece_t p;
		piece_kind_e kind;
		square_t sq;
		logic own;
		view = '0;
		for (int c = 0; c < NUM_COLS; c++) begin
			for (int r = 0; r < NUM_ROWS; r++) begin
				p = bstate[(r*NUM_COLS + c)*PIECE_W +: PIECE_W];
				kind = piece_kind_e'(p[2:0]);
				sq = {coord_t'(c), coord_t'(r)};
				own = (p[3] == side_to_move);
				if (kind != EMPTY) begin
					view.friendly[sq] = own;
					view.enemy[sq] = !own;
				end
				// only our own pieces get moves
				view.knight[sq] = own && (kind == KNIGHT);
				view.king[sq] = own && (kind == KING);
			end
		end
	end

endmodule

// File: logic/column_move_gen.sv
`timescale 1ns/100ps

module column_move_gen #(
	parameter int COL = 0
) (
	input logic clk,
	input logic reset,
	input move_gen_pkg::board_view_t view,
	input logic fifo_full,
	output move_gen_pkg::move_t move,
	output logic push,
	output logic gen_done
);
	import move_gen_pkg::*;

	localparam coord_t COL_C = coord_t'(COL);
	localparam int OFF_W = $clog2(NUM_OFFSETS);

	gen_state_e state;
	coord_t row;
	logic [OFF_W-1:0] off_idx;

	square_t from_sq;
	square_t to_sq;
	delta_t dc;
	delta_t dr;
	logic signed [4:0] tc;
	logic signed [4:0] tr;
	logic piece_sq;
	logic on_board;
	logic want_push;
	logic stall;
	logic last_off;

	assign from_sq = {COL_C, row};
	assign piece_sq = view.knight[from_sq] | view.king[from_sq];

	// knight table unless the square holds a king
	assign dc = view.king[from_sq] ? KING_DC[off_idx] : KNIGHT_DC[off_idx];
	assign dr = view.king[from_sq] ? KING_DR[off_idx] : KNIGHT_DR[off_idx];

	assign tc = $signed({2'b00, COL_C}) + dc;
	assign tr = $signed({2'b00, row}) + dr;
	// negative or past 7 sets one of the top bits
	assign on_board = (tc[4:3] == 2'b00) && (tr[4:3] == 2'b00);
	assign to_sq = {tc[2:0], tr[2:0]};

	assign want_push = (state == GEN_SCAN) && piece_sq && on_board && !view.friendly[to_sq];
	assign push = want_push && !fifo_full;
	assign stall = want_push && fifo_full;
	assign last_off = (off_idx == OFF_W'(NUM_OFFSETS - 1));
	assign gen_done = (state == GEN_DONE);

	always_comb begin
		move = '0;
		move.flags[FLAG_CAPTURE] = view.enemy[to_sq];
		move.from_sq = from_sq;
		move.to_sq = to_sq;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= GEN_SCAN;
			row <= '0;
			off_idx <= '0;
		end else if ((state == GEN_SCAN) && !stall) begin
			if (piece_sq && !last_off) begin
				off_idx <= off_idx + 1'b1;
			end else begin
				// empty or other piece costs one cycle
				off_idx <= '0;
				if (row == coord_t'(NUM_ROWS - 1)) begin
					state <= GEN_DONE;
				end else begin
					row <= row + 1'b1;
				end
			end
		end
	end

	a_no_push_full: assert property (
		@(posedge clk) disable iff (reset)
		fifo_full |-> !push
	);

	// held-back move is offered again unchanged
	a_stall_hold: assert property (
		@(posedge clk) disable iff (reset)
		stall |=> want_push && $stable(move)
	);

endmodule

// File: logic/move_fifo.sv
`timescale 1ns/100ps

module move_fifo #(
	parameter int DEPTH = 8
) (
	input logic clk,
	input logic reset,
	input move_gen_pkg::move_t wr_data,
	input logic push,
	input logic pop,
	output move_gen_pkg::move_t rd_data,
	output logic full,
	output logic empty
);
	import move_gen_pkg::*;

	localparam int AW = $clog2(DEPTH);

	move_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;
	logic do_push;
	logic do_pop;

	assign full = (count == (AW+1)'(DEPTH));
	assign empty = (count == '0);
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// head word is visible without a read cycle
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + (AW+1)'(do_push) - (AW+1)'(do_pop);
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (reset) full |-> !push);
	a_no_underflow: assert property (@(posedge clk) disable iff (reset) empty |-> !pop);

endmodule

// File: logic/move_collector.sv
`timescale 1ns/100ps

module move_collector (
	input logic clk,
	input logic reset,
	input move_gen_pkg::move_t col_heads [move_gen_pkg::NUM_COLS],
	input logic [move_gen_pkg::NUM_COLS-1:0] col_empty,
	input logic [move_gen_pkg::NUM_COLS-1:0] col_done,
	input logic out_full,
	output logic [move_gen_pkg::NUM_COLS-1:0] col_pop,
	output move_gen_pkg::move_t out_move,
	output logic out_push,
	output logic done
);
	import move_gen_pkg::*;

	coll_state_e state;
	coord_t col_ptr;

	logic ptr_empty;
	logic ptr_finished;
	logic last_col;
	logic xfer;

	assign ptr_empty = col_empty[col_ptr];
	// no more pushes once gen_done is up
	assign ptr_finished = col_done[col_ptr] && ptr_empty;
	assign last_col = (col_ptr == coord_t'(NUM_COLS - 1));

	// pop and push in the same cycle
	assign xfer = (state == GETM) && !ptr_empty && !out_full;
	assign out_push = xfer;
	assign out_move = col_heads[col_ptr];
	assign done = (state == DONE);

	always_comb begin
		col_pop = '0;
		col_pop[col_ptr] = xfer;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= WAIT;
			col_ptr <= '0;
		end else begin
			case (state)
				WAIT: begin
					if (!ptr_empty) begin
						state <= GETM;
					end else if (ptr_finished) begin
						if (last_col) begin
							state <= DONE;
						end else begin
							col_ptr <= col_ptr + 1'b1;
						end
					end
				end
				GETM: begin
					// back to WAIT to see if the column is finished
					if (ptr_empty) begin
						state <= WAIT;
					end
				end
				DONE: state <= DONE;
				default: state <= WAIT;
			endcase
		end
	end

	a_pop_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(col_pop));

	// done only once every column is finished and drained
	a_done_drained: assert property (
		@(posedge clk) disable iff (reset)
		done |-> (&col_done) && (&col_empty)
	);

endmodule

// File: logic/move_gen_top.sv
`timescale 1ns/100ps

module move_gen_top (
	input logic clk,
	input logic reset,
	input move_gen_pkg::board_t bstate,
	input logic side_to_move,
	input logic rden,
	output move_gen_pkg::move_t move_out,
	output logic move_valid,
	output logic done
);
	import move_gen_pkg::*;

	board_view_t view;
	move_t gen_move [NUM_COLS];
	move_t col_heads [NUM_COLS];
	logic [NUM_COLS-1:0] gen_push;
	logic [NUM_COLS-1:0] col_full;
	logic [NUM_COLS-1:0] col_done;
	logic [NUM_COLS-1:0] col_empty;
	logic [NUM_COLS-1:0] col_pop;
	move_t out_move;
	logic out_push;
	logic out_full;
	logic out_empty;
	logic out_pop;

	board_decoder decoder_inst (
		.bstate(bstate),
		.side_to_move(side_to_move),
		.view(view)
	);

	for (genvar c = 0; c < NUM_COLS; c++) begin : g_col
		column_move_gen #(.COL(c)) gen_inst (
			.clk(clk),
			.reset(reset),
			.view(view),
			.fifo_full(col_full[c]),
			.move(gen_move[c]),
			.push(gen_push[c]),
			.gen_done(col_done[c])
		);

		move_fifo #(.DEPTH(COL_FIFO_DEPTH)) fifo_inst (
			.clk(clk),
			.reset(reset),
			.wr_data(gen_move[c]),
			.push(gen_push[c]),
			.pop(col_pop[c]),
			.rd_data(col_heads[c]),
			.full(col_full[c]),
			.empty(col_empty[c])
		);
	end

	move_collector collector_inst (
		.clk(clk),
		.reset(reset),
		.col_heads(col_heads),
		.col_empty(col_empty),
		.col_done(col_done),
		.out_full(out_full),
		.col_pop(col_pop),
		.out_move(out_move),
		.out_push(out_push),
		.done(done)
	);

	// rden strobe on an empty FIFO is dropped
	assign out_pop = rden && !out_empty;
	assign move_valid = !out_empty;

	move_fifo #(.DEPTH(OUT_FIFO_DEPTH)) out_fifo_inst (
		.clk(clk),
		.reset(reset),
		.wr_data(out_move),
		.push(out_push),
		.pop(out_pop),
		.rd_data(move_out),
		.full(out_full),
		.empty(out_empty)
	);

endmodule

// File: include/move_ref_model.svh
`ifndef MOVE_REF_MODEL_SVH
`define MOVE_REF_MODEL_SVH

function automatic move_gen_pkg::piece_t ref_piece(input move_gen_pkg::board_t b,
	input int c, input int r);
	return b[32*r + 4*c +: 4];
endfunction

// expected moves in column, row, offset order
function automatic void ref_build_moves(input move_gen_pkg::board_t b, input logic side,
	output move_gen_pkg::move_t exp_q[$]);
	move_gen_pkg::piece_t p;
	move_gen_pkg::piece_t t;
	move_gen_pkg::move_t m;
	logic is_king;
	int tc;
	int tr;
	exp_q = {};
	for (int c = 0; c < 8; c++) begin
		for (int r = 0; r < 8; r++) begin
			p = ref_piece(b, c, r);
			is_king = (p[2:0] == move_gen_pkg::KING);
			if (p[3] != side) continue;
			if (p[2:0] != move_gen_pkg::KNIGHT && !is_king) continue;
			for (int k = 0; k < move_gen_pkg::NUM_OFFSETS; k++) begin
				tc = c + int'(is_king ? move_gen_pkg::KING_DC[k] : move_gen_pkg::KNIGHT_DC[k]);
				tr = r + int'(is_king ? move_gen_pkg::KING_DR[k] : move_gen_pkg::KNIGHT_DR[k]);
				if (tc < 0 || tc > 7 || tr < 0 || tr > 7) continue;
				t = ref_piece(b, tc, tr);
				// own piece blocks the target
				if (t[2:0] != move_gen_pkg::EMPTY && t[3] == side) continue;
				m = '0;
				m.flags[move_gen_pkg::FLAG_CAPTURE] = (t[2:0] != move_gen_pkg::EMPTY);
				m.from_sq = {3'(c), 3'(r)};
				m.to_sq = {3'(tc), 3'(tr)};
				exp_q.push_back(m);
			end
		end
	end
endfunction

`endif

// File: dv/move_gen_tb.sv
`timescale 1ns/100ps

module move_gen_tb;
	import move_gen_pkg::*;

	`include "move_ref_model.svh"

	localparam int NUM_ENTRIES = 10;
	localparam int RESET_CYCLES = 10;
	localparam int HOLD_CYCLES = 100;
	localparam int ENTRY_CYCLES = 2000;

	logic clk;
	logic reset;
	board_t bstate;
	logic side_to_move;
	logic rden;
	move_t move_out;
	logic move_valid;
	logic done;

	board_t tab_board [NUM_ENTRIES];
	logic tab_side [NUM_ENTRIES];
	logic tab_hold [NUM_ENTRIES];
	int tab_count [NUM_ENTRIES];
	logic tab_has_first [NUM_ENTRIES];
	move_t tab_first [NUM_ENTRIES];

	integer seed;
	int errors;
	logic timed_out;

	move_gen_top move_gen_top_inst (
		.clk(clk),
		.reset(reset),
		.bstate(bstate),
		.side_to_move(side_to_move),
		.rden(rden),
		.move_out(move_out),
		.move_valid(move_valid),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic board_t place_piece(input board_t b, input int c, input int r,
		input piece_t p);
		board_t nb;
		nb = b;
		nb[32*r + 4*c +: 4] = p;
		return nb;
	endfunction

	// mostly empty with knights, kings and a few blockers
	task automatic make_random_board(output board_t b);
		integer v;
		piece_t p;
		b = '0;
		for (int sq = 0; sq < 64; sq++) begin
			v = $random(seed);
			case (v[3:0])
				4'd9, 4'd10, 4'd11: p = {v[4], 3'(KNIGHT)};
				4'd12, 4'd13: p = {v[4], 3'(KING)};
				4'd14: p = {v[4], 3'(PAWN)};
				4'd15: p = {v[4], 3'(ROOK)};
				default: p = '0;
			endcase
			b[4*sq +: 4] = p;
		end
	endtask

	task automatic build_table();
		board_t b;
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			tab_board[i] = '0;
			tab_side[i] = 1'b0;
			tab_hold[i] = 1'b0;
			tab_count[i] = -1;
			tab_has_first[i] = 1'b0;
			tab_first[i] = '0;
		end
		tab_count[0] = 0;
		// pawns and sliders only
		b = '0;
		for (int c = 0; c < 8; c++) begin
			b = place_piece(b, c, 1, 4'h1);
			b = place_piece(b, c, 6, 4'h9);
		end
		b = place_piece(b, 0, 0, 4'h4);
		b = place_piece(b, 2, 7, 4'hb);
		b = place_piece(b, 3, 0, 4'h5);
		tab_board[1] = place_piece(b, 3, 7, 4'hd);
		tab_count[1] = 0;
		// lone knight a1 with b3 first
		tab_board[2] = place_piece('0, 0, 0, 4'h2);
		tab_count[2] = 2;
		tab_has_first[2] = 1'b1;
		tab_first[2] = {7'h00, 6'o00, 6'o12};
		// lone king h8
		tab_board[3] = place_piece('0, 7, 7, 4'h6);
		tab_count[3] = 3;
		tab_has_first[3] = 1'b1;
		tab_first[3] = {7'h00, 6'o77, 6'o76};
		// own pawn blocks b3 and an enemy rook sits on c2
		b = place_piece('0, 0, 0, 4'h2);
		b = place_piece(b, 1, 2, 4'h1);
		tab_board[4] = place_piece(b, 2, 1, 4'hc);
		tab_count[4] = 1;
		tab_has_first[4] = 1'b1;
		tab_first[4] = {7'h01, 6'o00, 6'o21};
		// black to move so white pieces are the enemy
		b = place_piece('0, 0, 0, 4'ha);
		b = place_piece(b, 1, 2, 4'h1);
		b = place_piece(b, 2, 1, 4'h9);
		tab_board[5] = place_piece(b, 7, 7, 4'h2);
		tab_side[5] = 1'b1;
		tab_count[5] = 1;
		tab_has_first[5] = 1'b1;
		tab_first[5] = {7'h01, 6'o00, 6'o12};
		// four central knights and a king give 35 moves
		b = place_piece('0, 2, 2, 4'h2);
		b = place_piece(b, 5, 2, 4'h2);
		b = place_piece(b, 2, 5, 4'h2);
		b = place_piece(b, 5, 5, 4'h2);
		tab_board[6] = place_piece(b, 7, 0, 4'h6);
		tab_hold[6] = 1'b1;
		tab_count[6] = 35;
		for (int i = 7; i < NUM_ENTRIES; i++) begin
			make_random_board(tab_board[i]);
		end
		tab_side[8] = 1'b1;
		tab_hold[9] = 1'b1;
	endtask

	initial begin
		move_t exp_q[$];
		int got;
		int cyc;
		int want;
		seed = 32'h8666_5c52;
		errors = 0;
		timed_out = 1'b0;
		reset = 1'b1;
		bstate = '0;
		side_to_move = 1'b0;
		rden = 1'b0;
		build_table();
		for (int e = 0; e < NUM_ENTRIES && !timed_out; e++) begin
			@(negedge clk);
			reset = 1'b1;
			rden = 1'b0;
			bstate = tab_board[e];
			side_to_move = tab_side[e];
			repeat (RESET_CYCLES) @(negedge clk);
			reset = 1'b0;
			if (done !== 1'b0) begin
				$display("Fail done entry %0d after reset: got %h expected %h",
					e, done, 1'b0);
				errors++;
			end
			if (move_valid !== 1'b0) begin
				$display("Fail move_valid entry %0d after reset: got %h expected %h",
					e, move_valid, 1'b0);
				errors++;
			end
			ref_build_moves(tab_board[e], tab_side[e], exp_q);
			want = (tab_count[e] < 0) ? exp_q.size() : tab_count[e];
			got = 0;
			cyc = 0;
			forever begin
				@(negedge clk);
				cyc++;
				if (done && !move_valid) begin
					break;
				end
				if (cyc >= ENTRY_CYCLES) begin
					timed_out = 1'b1;
					break;
				end
				if (tab_hold[e] && cyc <= HOLD_CYCLES) begin
					rden = 1'b0;
					// output FIFO cannot hold them all yet
					if (done && exp_q.size() > OUT_FIFO_DEPTH) begin
						$display("Fail done entry %0d during hold: got %h expected %h",
							e, done, 1'b0);
						errors++;
					end
				end else if (move_valid) begin
					if (got >= exp_q.size()) begin
						$display("Fail move_out entry %0d: got %h expected none", e, move_out);
						errors++;
					end else if (move_out !== exp_q[got]) begin
						$display("Fail move_out entry %0d index %0d: got %h expected %h",
							e, got, move_out, exp_q[got]);
						errors++;
					end
					if (got == 0 && tab_has_first[e] && move_out !== tab_first[e]) begin
						$display("Fail move_out entry %0d first move: got %h expected %h",
							e, move_out, tab_first[e]);
						errors++;
					end
					got++;
					rden = 1'b1;
				end else begin
					rden = 1'b0;
				end
			end
			rden = 1'b0;
			if (timed_out) begin
				$display("Timeout: entry %0d did not finish within %0d cycles", e, ENTRY_CYCLES);
				errors++;
			end else if (got != want) begin
				$display("Fail move count entry %0d: got %h expected %h", e, got, want);
				errors++;
			end
		end
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: move_gen.f
logic/move_gen_pkg.sv
logic/board_decoder.sv
logic/column_move_gen.sv
logic/move_fifo.sv
logic/move_collector.sv
logic/move_gen_top.sv
+incdir+include
dv/move_gen_tb.sv
